// ==== common/bp_params.svh ====
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

//****************************************
// predictor sizing
//****************************************

// branch pc width
`define BP_PC_WIDTH 32

// all three tables index with pc[9:2]
`define BP_INDEX_WIDTH 8

// global history length matches the index for the xor hash
`define BP_HIST_WIDTH `BP_INDEX_WIDTH

//****************************************
// counter init
//****************************************

// weakly not-taken
`define BP_CTR_RESET 2'd1

`endif

// ==== common/bp_state_pkg.sv ====
`default_nettype none

package bp_state_pkg;

	//****************************************
	// two-bit saturating counter
	//****************************************

	// upper half predicts taken
	typedef enum logic [1:0] {
		STRONG_NT = 2'd0,
		WEAK_NT   = 2'd1,
		WEAK_T    = 2'd2,
		STRONG_T  = 2'd3
	} ctr_state_t;

	//****************************************
	// prediction source
	//****************************************

	// chooser upper half picks global
	typedef enum logic {
		SRC_LOCAL  = 1'b0,
		SRC_GLOBAL = 1'b1
	} pred_src_t;

endpackage

`default_nettype wire

// ==== common/bp_port_pkg.sv ====
`default_nettype none

`include "bp_params.svh"

package bp_port_pkg;

	//****************************************
	// fetch side
	//****************************************

	// one-cycle pc strobe
	typedef struct packed {
		logic                      valid;
		logic [`BP_PC_WIDTH-1:0]   pc;
	} pred_req_t;

	// registered prediction one cycle after the request
	typedef struct packed {
		logic                        valid;
		logic                        taken;
		logic                        local_taken;
		logic                        global_taken;
		bp_state_pkg::pred_src_t     src;
		// history used for the global index
		logic [`BP_HIST_WIDTH-1:0]   history;
	} pred_rsp_t;

	//****************************************
	// commit side
	//****************************************

	// history and component bits are echoed from the response
	typedef struct packed {
		logic                        valid;
		logic [`BP_PC_WIDTH-1:0]     pc;
		logic [`BP_HIST_WIDTH-1:0]   history;
		// actual outcome
		logic                        taken;
		logic                        local_taken;
		logic                        global_taken;
	} train_req_t;

endpackage

`default_nettype wire

// ==== rtl/counter_table.sv ====
`default_nettype none

`include "bp_params.svh"

module counter_table #(
	parameter int INDEX_WIDTH = `BP_INDEX_WIDTH
) (
	input  wire logic                      clk,
	input  wire logic                      reset_i,
	input  wire logic [INDEX_WIDTH-1:0]    rd_idx_i,
	input  wire logic                      upd_en_i,
	input  wire logic [INDEX_WIDTH-1:0]    upd_idx_i,
	input  wire logic                      upd_up_i,
	output bp_state_pkg::ctr_state_t       rd_state_o
);
	import bp_state_pkg::*;

	localparam int DEPTH = 1 << INDEX_WIDTH;

	ctr_state_t table_q [DEPTH];
	ctr_state_t upd_cur;
	ctr_state_t upd_next;

	// combinational read while training lands at the next edge
	assign rd_state_o = table_q[rd_idx_i];

	//****************************************
	// saturating step
	//****************************************
	always_comb begin
		upd_cur  = table_q[upd_idx_i];
		upd_next = upd_cur;
		if (upd_up_i) begin
			if (upd_cur != STRONG_T) begin
				upd_next = ctr_state_t'(upd_cur + 2'd1);
			end
		end else begin
			if (upd_cur != STRONG_NT) begin
				upd_next = ctr_state_t'(upd_cur - 2'd1);
			end
		end
	end

	//****************************************
	// counter array
	//****************************************
	always_ff @(posedge clk) begin
		if (reset_i) begin
			// every entry back to weakly not-taken
			for (int i = 0; i < DEPTH; i++) begin
				table_q[i] <= ctr_state_t'(`BP_CTR_RESET);
			end
		end else if (upd_en_i) begin
			table_q[upd_idx_i] <= upd_next;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/pred_select.sv ====
`default_nettype none

`include "bp_params.svh"

module pred_select (
	input  wire logic                        clk,
	input  wire logic                        reset_i,
	input  wire logic                        req_valid_i,
	input  bp_state_pkg::ctr_state_t         local_state_i,
	input  bp_state_pkg::ctr_state_t         global_state_i,
	input  bp_state_pkg::ctr_state_t         chooser_state_i,
	input  wire logic [`BP_HIST_WIDTH-1:0]   history_i,
	output bp_port_pkg::pred_rsp_t           pred_rsp_o
);
	import bp_state_pkg::*;

	logic      local_taken;
	logic      global_taken;
	logic      final_taken;
	pred_src_t src;

	logic                      valid_q;
	logic                      taken_q;
	logic                      local_taken_q;
	logic                      global_taken_q;
	pred_src_t                 src_q;
	logic [`BP_HIST_WIDTH-1:0] history_q;

	// upper half of a counter means taken
	function automatic logic ctr_taken(input ctr_state_t state);
		return (state == WEAK_T) || (state == STRONG_T);
	endfunction

	//****************************************
	// tournament pick
	//****************************************
	assign local_taken  = ctr_taken(local_state_i);
	assign global_taken = ctr_taken(global_state_i);
	assign src          = ctr_taken(chooser_state_i) ? SRC_GLOBAL : SRC_LOCAL;
	assign final_taken  = (src == SRC_GLOBAL) ? global_taken : local_taken;

	//****************************************
	// response register
	//****************************************
	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= req_valid_i;
		end
	end

	// payload only moves on a request
	always_ff @(posedge clk) begin
		if (req_valid_i) begin
			taken_q        <= final_taken;
			local_taken_q  <= local_taken;
			global_taken_q <= global_taken;
			src_q          <= src;
			history_q      <= history_i;
		end
	end

	assign pred_rsp_o.valid        = valid_q;
	assign pred_rsp_o.taken        = taken_q;
	assign pred_rsp_o.local_taken  = local_taken_q;
	assign pred_rsp_o.global_taken = global_taken_q;
	assign pred_rsp_o.src          = src_q;
	assign pred_rsp_o.history      = history_q;

endmodule

`default_nettype wire

// ==== rtl/bp_ctrl.sv ====
`default_nettype none

`include "bp_params.svh"

module bp_ctrl (
	input  wire logic                         clk,
	input  wire logic                         reset_i,
	input  bp_port_pkg::pred_req_t            pred_req_i,
	input  bp_port_pkg::train_req_t           train_i,
	// read side
	output logic [`BP_INDEX_WIDTH-1:0]        local_rd_idx_o,
	output logic [`BP_INDEX_WIDTH-1:0]        global_rd_idx_o,
	output logic [`BP_INDEX_WIDTH-1:0]        chooser_rd_idx_o,
	// local table update
	output logic                              local_upd_en_o,
	output logic [`BP_INDEX_WIDTH-1:0]        local_upd_idx_o,
	output logic                              local_upd_up_o,
	// global table update
	output logic                              global_upd_en_o,
	output logic [`BP_INDEX_WIDTH-1:0]        global_upd_idx_o,
	output logic                              global_upd_up_o,
	// chooser update
	output logic                              chooser_upd_en_o,
	output logic [`BP_INDEX_WIDTH-1:0]        chooser_upd_idx_o,
	output logic                              chooser_upd_up_o,
	output logic [`BP_HIST_WIDTH-1:0]         history_o,
	output logic                              req_valid_o
);

	logic [`BP_HIST_WIDTH-1:0]  history_q;
	logic [`BP_INDEX_WIDTH-1:0] req_pc_idx;
	logic [`BP_INDEX_WIDTH-1:0] train_pc_idx;
	logic                       comp_disagree;

	//****************************************
	// global history
	//****************************************

	// only committed outcomes shift in
	always_ff @(posedge clk) begin
		if (reset_i) begin
			history_q <= '0;
		end else if (train_i.valid) begin
			history_q <= {history_q[`BP_HIST_WIDTH-2:0], train_i.taken};
		end
	end

	assign history_o   = history_q;
	assign req_valid_o = pred_req_i.valid;

	//****************************************
	// index hashing
	//****************************************

	// word aligned pc drops the low two bits
	assign req_pc_idx   = pred_req_i.pc[`BP_INDEX_WIDTH+1:2];
	assign train_pc_idx = train_i.pc[`BP_INDEX_WIDTH+1:2];

	// reads see the history before this cycle's training
	assign local_rd_idx_o   = req_pc_idx;
	assign global_rd_idx_o  = req_pc_idx ^ history_q;
	assign chooser_rd_idx_o = req_pc_idx;

	//****************************************
	// training
	//****************************************

	// both components follow the actual outcome
	assign local_upd_en_o  = train_i.valid;
	assign local_upd_idx_o = train_pc_idx;
	assign local_upd_up_o  = train_i.taken;

	// global entry uses the snapshot taken at prediction time
	assign global_upd_en_o  = train_i.valid;
	assign global_upd_idx_o = train_pc_idx ^ train_i.history;
	assign global_upd_up_o  = train_i.taken;

	// chooser learns only when the components disagree
	assign comp_disagree = train_i.local_taken != train_i.global_taken;

	assign chooser_upd_en_o  = train_i.valid & comp_disagree;
	assign chooser_upd_idx_o = train_pc_idx;
	// up favors global
	assign chooser_upd_up_o  = train_i.global_taken == train_i.taken;

endmodule

`default_nettype wire

// ==== rtl/bp_top.sv ====
`default_nettype none

`include "bp_params.svh"

module bp_top (
	input  wire logic                 clk,
	input  wire logic                 reset_i,
	input  bp_port_pkg::pred_req_t    pred_req_i,
	input  bp_port_pkg::train_req_t   train_i,
	output bp_port_pkg::pred_rsp_t    pred_rsp_o
);
	import bp_state_pkg::*;

	//****************************************
	// control to tables
	//****************************************
	logic [`BP_INDEX_WIDTH-1:0] local_rd_idx;
	logic [`BP_INDEX_WIDTH-1:0] global_rd_idx;
	logic [`BP_INDEX_WIDTH-1:0] chooser_rd_idx;

	logic                       local_upd_en;
	logic [`BP_INDEX_WIDTH-1:0] local_upd_idx;
	logic                       local_upd_up;
	logic                       global_upd_en;
	logic [`BP_INDEX_WIDTH-1:0] global_upd_idx;
	logic                       global_upd_up;
	logic                       chooser_upd_en;
	logic [`BP_INDEX_WIDTH-1:0] chooser_upd_idx;
	logic                       chooser_upd_up;

	logic [`BP_HIST_WIDTH-1:0]  history;
	logic                       req_valid;

	// table reads into the select stage
	ctr_state_t local_state;
	ctr_state_t global_state;
	ctr_state_t chooser_state;

	bp_ctrl u_ctrl (
		.clk               (clk            ),
		.reset_i           (reset_i        ),
		.pred_req_i        (pred_req_i     ),
		.train_i           (train_i        ),
		.local_rd_idx_o    (local_rd_idx   ),
		.global_rd_idx_o   (global_rd_idx  ),
		.chooser_rd_idx_o  (chooser_rd_idx ),
		.local_upd_en_o    (local_upd_en   ),
		.local_upd_idx_o   (local_upd_idx  ),
		.local_upd_up_o    (local_upd_up   ),
		.global_upd_en_o   (global_upd_en  ),
		.global_upd_idx_o  (global_upd_idx ),
		.global_upd_up_o   (global_upd_up  ),
		.chooser_upd_en_o  (chooser_upd_en ),
		.chooser_upd_idx_o (chooser_upd_idx),
		.chooser_upd_up_o  (chooser_upd_up ),
		.history_o         (history        ),
		.req_valid_o       (req_valid      )
	);

	//****************************************
	// counter tables
	//****************************************
	counter_table u_local (
		.clk        (clk          ),
		.reset_i    (reset_i      ),
		.rd_idx_i   (local_rd_idx ),
		.upd_en_i   (local_upd_en ),
		.upd_idx_i  (local_upd_idx),
		.upd_up_i   (local_upd_up ),
		.rd_state_o (local_state  )
	);

	counter_table u_global (
		.clk        (clk           ),
		.reset_i    (reset_i       ),
		.rd_idx_i   (global_rd_idx ),
		.upd_en_i   (global_upd_en ),
		.upd_idx_i  (global_upd_idx),
		.upd_up_i   (global_upd_up ),
		.rd_state_o (global_state  )
	);

	counter_table u_chooser (
		.clk        (clk            ),
		.reset_i    (reset_i        ),
		.rd_idx_i   (chooser_rd_idx ),
		.upd_en_i   (chooser_upd_en ),
		.upd_idx_i  (chooser_upd_idx),
		.upd_up_i   (chooser_upd_up ),
		.rd_state_o (chooser_state  )
	);

	pred_select u_select (
		.clk             (clk          ),
		.reset_i         (reset_i      ),
		.req_valid_i     (req_valid    ),
		.local_state_i   (local_state  ),
		.global_state_i  (global_state ),
		.chooser_state_i (chooser_state),
		.history_i       (history      ),
		.pred_rsp_o      (pred_rsp_o   )
	);

endmodule

`default_nettype wire

// ==== tests/bp_asserts.sv ====
`default_nettype none

module bp_asserts (
	input  wire logic               clk,
	input  wire logic               reset_i,
	input  bp_port_pkg::pred_req_t  pred_req_i,
	input  bp_port_pkg::pred_rsp_t  pred_rsp_i
);
	import bp_state_pkg::*;

	int unsigned fail_count = 0;

	//****************************************
	// response timing
	//****************************************
	rsp_follows_req: assert property (@(posedge clk) disable iff (reset_i)
		pred_req_i.valid |=> pred_rsp_i.valid)
		else begin
			fail_count++;
			$error("no response one cycle after a request");
		end

	// a response needs a request the cycle before
	no_spurious_rsp: assert property (@(posedge clk) disable iff (reset_i)
		!pred_req_i.valid |=> !pred_rsp_i.valid)
		else begin
			fail_count++;
			$error("response without a request");
		end

	taken_from_src: assert property (@(posedge clk) disable iff (reset_i)
		pred_rsp_i.valid |-> pred_rsp_i.taken == ((pred_rsp_i.src == SRC_GLOBAL) ?
			pred_rsp_i.global_taken : pred_rsp_i.local_taken))
		else begin
			fail_count++;
			$error("taken does not match the selected component");
		end

endmodule

bind bp_top bp_asserts u_asserts (
	.clk        (clk       ),
	.reset_i    (reset_i   ),
	.pred_req_i (pred_req_i),
	.pred_rsp_i (pred_rsp_o)
);

`default_nettype wire

// ==== tests/bp_tb.sv ====
`default_nettype none

`include "bp_params.svh"

module bp_tb;
	import bp_state_pkg::*;
	import bp_port_pkg::*;

	localparam int ENTRIES       = 1 << `BP_INDEX_WIDTH;
	localparam int RESET_CYCLES  = 8;
	localparam int ALT_ROUNDS    = 24;
	localparam int HIST_CYCLES   = 200;
	localparam int RANDOM_CYCLES = 2000;
	// directed tests take well under 120 cycles
	localparam int TEST_CYCLES   = RESET_CYCLES + 120 + 3 * ALT_ROUNDS + HIST_CYCLES
		+ RANDOM_CYCLES;
	localparam int WATCHDOG_CYCLES = TEST_CYCLES + 500;

	localparam logic [`BP_PC_WIDTH-1:0] PC_A = 32'h0000_0100;
	localparam logic [`BP_PC_WIDTH-1:0] PC_B = 32'h0000_0104;
	localparam logic [`BP_PC_WIDTH-1:0] PC_C = 32'h0000_0200;
	localparam logic [`BP_PC_WIDTH-1:0] PC_D = 32'h0000_0300;

	logic       clk;
	logic       reset_i;
	pred_req_t  pred_req;
	train_req_t train;
	pred_rsp_t  pred_rsp;

	bp_top DUT (
		.clk        (clk     ),
		.reset_i    (reset_i ),
		.pred_req_i (pred_req),
		.train_i    (train   ),
		.pred_rsp_o (pred_rsp)
	);

	//****************************************
	// reference model
	//****************************************
	logic [1:0]                local_m   [ENTRIES];
	logic [1:0]                global_m  [ENTRIES];
	logic [1:0]                chooser_m [ENTRIES];
	logic [`BP_HIST_WIDTH-1:0] hist_m;

	// response expected one cycle after the request
	pred_rsp_t                 exp_pend;
	logic [`BP_PC_WIDTH-1:0]   exp_pend_pc;
	string                     exp_pend_test;
	pred_rsp_t                 last_rsp;
	train_req_t                echo_q [$];
	string                     test_name;
	int unsigned               check_count;
	int unsigned               mismatch_count;

	function automatic logic [1:0] sat_step(input logic [1:0] v, input logic up);
		if (up) begin
			return (v == 2'd3) ? v : v + 2'd1;
		end
		return (v == 2'd0) ? v : v - 2'd1;
	endfunction

	// bit 1 of a counter is its taken vote
	function automatic pred_rsp_t model_predict(input logic [`BP_PC_WIDTH-1:0] pc);
		pred_rsp_t                  r;
		logic [`BP_INDEX_WIDTH-1:0] idx;
		idx            = pc[`BP_INDEX_WIDTH+1:2];
		r.valid        = 1'b1;
		r.local_taken  = local_m[idx][1];
		r.global_taken = global_m[idx ^ hist_m][1];
		r.src          = chooser_m[idx][1] ? SRC_GLOBAL : SRC_LOCAL;
		r.taken        = chooser_m[idx][1] ? r.global_taken : r.local_taken;
		r.history      = hist_m;
		return r;
	endfunction

	function automatic void model_train(input train_req_t t);
		logic [`BP_INDEX_WIDTH-1:0] idx;
		logic [`BP_INDEX_WIDTH-1:0] gidx;
		idx            = t.pc[`BP_INDEX_WIDTH+1:2];
		gidx           = idx ^ t.history;
		local_m[idx]   = sat_step(local_m[idx], t.taken);
		global_m[gidx] = sat_step(global_m[gidx], t.taken);
		if (t.local_taken != t.global_taken) begin
			chooser_m[idx] = sat_step(chooser_m[idx], t.global_taken == t.taken);
		end
		hist_m = {hist_m[`BP_HIST_WIDTH-2:0], t.taken};
	endfunction

	function automatic train_req_t make_train(input logic [`BP_PC_WIDTH-1:0] pc,
			input pred_rsp_t rsp, input logic taken);
		train_req_t t;
		t.valid        = 1'b1;
		t.pc           = pc;
		t.history      = rsp.history;
		t.taken        = taken;
		t.local_taken  = rsp.local_taken;
		t.global_taken = rsp.global_taken;
		return t;
	endfunction

	// small pc pool so entries get reused
	function automatic logic [`BP_PC_WIDTH-1:0] pool_pc();
		return 32'h0040_0000 + 32'($urandom_range(0, 7)) * 32'd20;
	endfunction

	//****************************************
	// checks
	//****************************************
	task automatic check_field(input string test, input string field,
			input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		assert (exp == act) else begin
			$display("MISMATCH test=%s field=%s expected=%0h actual=%0h",
				test, field, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic check_response();
		if (exp_pend.valid) begin
			check_field(exp_pend_test, "valid", 32'd1, 32'(pred_rsp.valid));
			check_field(exp_pend_test, "taken", 32'(exp_pend.taken), 32'(pred_rsp.taken));
			check_field(exp_pend_test, "local_taken", 32'(exp_pend.local_taken),
				32'(pred_rsp.local_taken));
			check_field(exp_pend_test, "global_taken", 32'(exp_pend.global_taken),
				32'(pred_rsp.global_taken));
			check_field(exp_pend_test, "src", 32'(exp_pend.src), 32'(pred_rsp.src));
			check_field(exp_pend_test, "history", 32'(exp_pend.history),
				32'(pred_rsp.history));
			last_rsp = pred_rsp;
			// keep a few snapshots for later commits
			echo_q.push_back(make_train(exp_pend_pc, pred_rsp, 1'b0));
			if (echo_q.size() > 16) begin
				void'(echo_q.pop_front());
			end
		end else begin
			check_field(exp_pend_test, "valid", 32'd0, 32'(pred_rsp.valid));
		end
	endtask

	//****************************************
	// stimulus
	//****************************************

	// model reads before this cycle's training
	task automatic run_cycle(input logic req_v, input logic [`BP_PC_WIDTH-1:0] req_pc,
			input train_req_t t);
		pred_req_t req;
		pred_rsp_t next_exp;
		req.valid = req_v;
		req.pc    = req_pc;
		next_exp  = '0;
		@(posedge clk);
		pred_req <= req;
		train    <= t;
		if (req_v) begin
			next_exp = model_predict(req_pc);
		end
		if (t.valid) begin
			model_train(t);
		end
		@(negedge clk);
		check_response();
		exp_pend      = next_exp;
		exp_pend_pc   = req_pc;
		exp_pend_test = test_name;
	endtask

	// leaves the response in last_rsp
	task automatic predict_once(input logic [`BP_PC_WIDTH-1:0] pc);
		run_cycle(1'b1, pc, '0);
		run_cycle(1'b0, '0, '0);
	endtask

	task automatic train_once(input logic [`BP_PC_WIDTH-1:0] pc, input logic taken);
		run_cycle(1'b0, '0, make_train(pc, last_rsp, taken));
	endtask

	task automatic random_traffic(input int cycles, input int req_pct, input int train_pct);
		train_req_t t;
		logic       req_v;
		for (int i = 0; i < cycles; i++) begin
			t     = '0;
			req_v = ($urandom_range(0, 99) < req_pct);
			if (echo_q.size() > 0 && $urandom_range(0, 99) < train_pct) begin
				t       = echo_q.pop_front();
				t.taken = 1'($urandom_range(0, 1));
			end
			run_cycle(req_v, pool_pc(), t);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	//****************************************
	// main sequence
	//****************************************
	initial begin
		logic      alt_taken;
		pred_rsp_t alt_exp;
		void'($urandom(32'hcc5b));
		reset_i  <= 1'b1;
		pred_req <= '0;
		train    <= '0;
		for (int i = 0; i < ENTRIES; i++) begin
			local_m[i]   = 2'd1;
			global_m[i]  = 2'd1;
			chooser_m[i] = 2'd1;
		end
		hist_m         = '0;
		exp_pend       = '0;
		exp_pend_pc    = '0;
		last_rsp       = '0;
		check_count    = 0;
		mismatch_count = 0;
		test_name      = "reset_state";
		exp_pend_test  = test_name;
		repeat (RESET_CYCLES) @(posedge clk);
		reset_i <= 1'b0;

		// fresh tables predict not-taken through local with zero history
		for (int i = 0; i < 16; i++) begin
			run_cycle(1'b1, $urandom(), '0);
			if (i > 0) begin
				check_field(test_name, "reset_rsp", 32'd0, 32'({last_rsp.taken,
					last_rsp.local_taken, last_rsp.global_taken, last_rsp.src,
					last_rsp.history}));
			end
		end
		run_cycle(1'b0, '0, '0);

		test_name = "train_taken";
		for (int i = 0; i < 2; i++) begin
			predict_once(PC_A);
			train_once(PC_A, 1'b1);
		end
		run_cycle(1'b1, PC_A, '0);
		run_cycle(1'b1, PC_B, '0);
		check_field(test_name, "taken_a", 32'd1, 32'(last_rsp.taken));
		check_field(test_name, "src_a", 32'(SRC_LOCAL), 32'(last_rsp.src));
		run_cycle(1'b0, '0, '0);
		check_field(test_name, "taken_b", 32'd0, 32'(last_rsp.taken));

		test_name = "same_cycle";
		predict_once(PC_C);
		run_cycle(1'b1, PC_C, make_train(PC_C, last_rsp, 1'b1));
		run_cycle(1'b1, PC_C, '0);
		check_field(test_name, "taken_before", 32'd0, 32'(last_rsp.taken));
		run_cycle(1'b0, '0, '0);
		check_field(test_name, "taken_after", 32'd1, 32'(last_rsp.taken));

		// local keeps missing while global learns the pattern
		test_name = "alternating";
		alt_taken = 1'b1;
		for (int i = 0; i < ALT_ROUNDS; i++) begin
			predict_once(PC_D);
			train_once(PC_D, alt_taken);
			alt_taken = ~alt_taken;
		end
		predict_once(PC_D);
		alt_exp = model_predict(PC_D);
		check_field(test_name, "src", 32'(SRC_GLOBAL), 32'(last_rsp.src));
		check_field(test_name, "taken", 32'(alt_exp.global_taken), 32'(last_rsp.taken));

		test_name = "history";
		random_traffic(HIST_CYCLES, 100, 100);

		test_name = "random";
		random_traffic(RANDOM_CYCLES, 70, 50);
		run_cycle(1'b0, '0, '0);

		$display("checks=%0d mismatches=%0d assert_failures=%0d",
			check_count, mismatch_count, DUT.u_asserts.fail_count);
		if (mismatch_count == 0 && DUT.u_asserts.fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/bp_state_pkg.sv
common/bp_port_pkg.sv
rtl/counter_table.sv
rtl/pred_select.sv
rtl/bp_ctrl.sv
rtl/bp_top.sv
tests/bp_asserts.sv
tests/bp_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := bp_tb
FILELIST  := sim.f
RUN_FLAGS := +verilator+error+limit+1000

SIM     := obj_dir/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuild only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only if the status line shows up in the output
run: $(SIM)
	@out=$$(./$(SIM) $(RUN_FLAGS)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
